// ==== protected_mem_1rw_d1024_w46.f ====
verilog/mem_pkg.sv
verilog/fakeram130_1024x8.sv
verilog/hard_mem_1rw_d1024_w46_wrapper.sv
verilog/parity_mem_1rw_d1024_w6.sv
verilog/mem_read_check.sv
verilog/protected_mem_1rw_d1024_w46.sv
tests/protected_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the parity-protected memory testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module protected_mem_tb \
  -f protected_mem_1rw_d1024_w46.f \
  -o protected_mem_sim \
  && ./obj_dir/protected_mem_sim > "$LOG" 2>&1 \
  || { cat "$LOG" 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -qx "NO ERRORS" "$LOG" && exit 0 || exit 1

// ==== tests/protected_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module protected_mem_tb;

  localparam int TABLE_MAX = 128;
  localparam int RESET_CYCLES = 16;

  localparam logic [1:0] OP_IDLE  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_READ  = 2'd2;

  // One table row, stimulus plus the response expected one cycle later
  typedef struct packed {
    logic [1:0]                         op;
    logic [mem_pkg::MEM_ADDR_WIDTH-1:0] addr;
    logic [mem_pkg::MEM_DATA_WIDTH-1:0] data;
    logic [mem_pkg::MEM_NUM_SLICES-1:0] inject;
    logic                               exp_valid;
    logic [mem_pkg::MEM_DATA_WIDTH-1:0] exp_data;
    logic [mem_pkg::MEM_NUM_SLICES-1:0] exp_err;
  } entry_t;

  logic              clk_i;
  logic              reset_i;
  mem_pkg::mem_req_t req_i;
  mem_pkg::mem_rsp_t rsp_o;

  entry_t stim_table [0:TABLE_MAX-1];
  int     n_entries;

  // Reference contents, updated as write rows are added
  logic [mem_pkg::MEM_DATA_WIDTH-1:0] shadow_data   [0:mem_pkg::MEM_DEPTH-1];
  logic [mem_pkg::MEM_NUM_SLICES-1:0] shadow_inject [0:mem_pkg::MEM_DEPTH-1];

  integer seed;
  int     errors;
  int     checks;
  int     cycle_count = 0;
  int     cycle_limit = 1000; // Replaced once the table is built

  protected_mem_1rw_d1024_w46 protected_mem_1rw_d1024_w46_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .rsp_o   (rsp_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [mem_pkg::MEM_DATA_WIDTH-1:0] random_word();
    logic [63:0] raw;
    raw[63:32] = $random(seed);
    raw[31:0]  = $random(seed);
    return raw[mem_pkg::MEM_DATA_WIDTH-1:0];
  endfunction

  task automatic store_entry(input entry_t e);
    assert (n_entries < TABLE_MAX) else begin
      errors++;
      $display("Stimulus table is full, row dropped");
    end
    if (n_entries < TABLE_MAX) begin
      stim_table[n_entries] = e;
      n_entries++;
    end
  endtask

  task automatic idle_entry();
    entry_t e;
    e = '0;
    e.op = OP_IDLE;
    store_entry(e);
  endtask

  task automatic write_entry(
    input logic [mem_pkg::MEM_ADDR_WIDTH-1:0] addr,
    input logic [mem_pkg::MEM_DATA_WIDTH-1:0] data,
    input logic [mem_pkg::MEM_NUM_SLICES-1:0] inject
  );
    entry_t e;
    e = '0;
    e.op     = OP_WRITE;
    e.addr   = addr;
    e.data   = data;
    e.inject = inject;
    shadow_data[addr]   = data;
    shadow_inject[addr] = inject; // Flipped parity shows up as a mismatch
    store_entry(e);
  endtask

  task automatic read_entry(input logic [mem_pkg::MEM_ADDR_WIDTH-1:0] addr);
    entry_t e;
    e = '0;
    e.op        = OP_READ;
    e.addr      = addr;
    e.exp_valid = 1'b1;
    e.exp_data  = shadow_data[addr];
    e.exp_err   = shadow_inject[addr];
    store_entry(e);
  endtask

  task automatic build_table();
    logic [mem_pkg::MEM_ADDR_WIDTH-1:0] word_addr [0:19];
    logic [mem_pkg::MEM_NUM_SLICES-1:0] fault_mask [0:5];
    logic [mem_pkg::MEM_ADDR_WIDTH-1:0] a;
    n_entries = 0;

    for (int k = 0; k < 4; k++) begin
      idle_entry(); // Quiet bus right after reset
    end

    // Twenty distinct addresses, both ends of the array included
    for (int k = 0; k < 20; k++) begin
      if (k == 0) begin
        word_addr[k] = 10'd0;
      end else if (k == 19) begin
        word_addr[k] = 10'd1023;
      end else begin
        word_addr[k] = 10'(7 + 53 * k);
      end
      write_entry(word_addr[k], random_word(), '0);
    end
    for (int k = 0; k < 20; k++) begin
      read_entry(word_addr[k]); // Back-to-back reads
    end
    idle_entry();

    // Read on the edge right after the write
    for (int k = 0; k < 4; k++) begin
      a = 10'(100 + k);
      write_entry(a, random_word(), '0);
      read_entry(a);
    end
    write_entry(word_addr[0], random_word(), '0); // Overwrite of an old word
    read_entry(word_addr[0]);

    fault_mask[0] = 6'h01;
    fault_mask[1] = 6'h20;
    fault_mask[2] = 6'h2a;
    fault_mask[3] = 6'h15;
    fault_mask[4] = 6'h3f;
    fault_mask[5] = 6'h00;
    for (int k = 0; k < 6; k++) begin
      a = 10'(700 + 3 * k);
      write_entry(a, random_word(), fault_mask[k]);
      idle_entry();
      read_entry(a);
    end

    // Clean rewrite removes the fault
    for (int k = 0; k < 6; k++) begin
      a = 10'(700 + 3 * k);
      write_entry(a, random_word(), '0);
      read_entry(a);
    end

    read_entry(word_addr[5]);
    read_entry(word_addr[19]);
    idle_entry();
    idle_entry();
  endtask

  task automatic drive_request(input entry_t e);
    req_i.v      = (e.op != OP_IDLE);
    req_i.w      = (e.op == OP_WRITE);
    req_i.addr   = e.addr;
    req_i.data   = e.data;
    req_i.inject = e.inject;
  endtask

  task automatic check_response(input entry_t e, input int idx);
    checks++;
    assert (rsp_o.valid === e.exp_valid) else begin
      errors++;
      $display("** Error: rsp_o.valid = %h, expected %h (row %0d)",
               rsp_o.valid, e.exp_valid, idx);
    end
    // Data only means something in a response cycle
    if (e.exp_valid) begin
      assert (rsp_o.data === e.exp_data) else begin
        errors++;
        $display("** Error: rsp_o.data = %h, expected %h (row %0d)",
                 rsp_o.data, e.exp_data, idx);
      end
    end
    assert (rsp_o.err_slices === e.exp_err) else begin
      errors++;
      $display("** Error: rsp_o.err_slices = %h, expected %h (row %0d)",
               rsp_o.err_slices, e.exp_err, idx);
    end
    assert (rsp_o.parity_err === (|e.exp_err)) else begin
      errors++;
      $display("** Error: rsp_o.parity_err = %h, expected %h (row %0d)",
               rsp_o.parity_err, |e.exp_err, idx);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    req_i   = '0;
    errors  = 0;
    checks  = 0;
    seed    = 32'h5b82_8164;

    build_table();
    cycle_limit = RESET_CYCLES + 4 * n_entries + 20;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    // Each response is checked one cycle after its row is driven
    for (int i = 0; i < n_entries; i++) begin
      @(posedge clk_i);
      #1;
      if (i > 0) begin
        check_response(stim_table[i-1], i - 1);
      end
      drive_request(stim_table[i]);
    end
    @(posedge clk_i);
    #1;
    check_response(stim_table[n_entries-1], n_entries - 1);
    req_i = '0;

    $display("Summary: %0d rows, %0d response checks, %0d errors",
             n_entries, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/protected_mem_1rw_d1024_w46.sv ====
`timescale 1ns/1ps
`default_nettype none

// Parity-protected 1024x46 single-port memory
module protected_mem_1rw_d1024_w46 (
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  input  mem_pkg::mem_req_t  req_i,
  output mem_pkg::mem_rsp_t  rsp_o
);

  logic [mem_pkg::MEM_DATA_WIDTH-1:0] array_data;
  logic [mem_pkg::MEM_NUM_SLICES-1:0] array_parity;
  logic                               read_strobe;

  assign read_strobe = req_i.v & ~req_i.w;

  // Data and parity arrays see the same access
  hard_mem_1rw_d1024_w46_wrapper data_array_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .v_i          (req_i.v),
    .w_i          (req_i.w),
    .write_mask_i (1'b1), // Whole-word writes only
    .addr_i       (req_i.addr),
    .data_i       (req_i.data),
    .data_o       (array_data)
  );

  parity_mem_1rw_d1024_w6 parity_array_inst (
    .clk_i    (clk_i),
    .v_i      (req_i.v),
    .w_i      (req_i.w),
    .addr_i   (req_i.addr),
    .data_i   (req_i.data),
    .inject_i (req_i.inject),
    .parity_o (array_parity)
  );

  mem_read_check read_check_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .read_i   (read_strobe),
    .data_i   (array_data),
    .parity_i (array_parity),
    .rsp_o    (rsp_o)
  );

endmodule

`default_nettype wire

// ==== verilog/mem_read_check.sv ====
`timescale 1ns/1ps
`default_nettype none

// Checks stored parity against the data read back and forms the response
module mem_read_check (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  input  wire logic                                read_i,   // v and not w, this cycle
  input  wire logic [mem_pkg::MEM_DATA_WIDTH-1:0]  data_i,   // From the data array
  input  wire logic [mem_pkg::MEM_NUM_SLICES-1:0]  parity_i, // From the parity array
  output mem_pkg::mem_rsp_t                        rsp_o
);

  logic                               read_q;     // Read issued on the last edge
  logic [mem_pkg::MEM_NUM_SLICES-1:0] calc_parity;
  logic [mem_pkg::MEM_NUM_SLICES-1:0] mismatch;

  // Macros return data one cycle after the read edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      read_q <= 1'b0;
    end else begin
      read_q <= read_i;
    end
  end

  assign calc_parity = mem_pkg::slice_parity(data_i);

  // Stored and recomputed parity differ in the faulty slices
  assign mismatch = calc_parity ^ parity_i;

  always_comb begin
    rsp_o.valid      = read_q;
    rsp_o.data       = data_i;
    // Array outputs are stale outside a response cycle
    rsp_o.err_slices = mismatch & {mem_pkg::MEM_NUM_SLICES{read_q}};
    rsp_o.parity_err = |rsp_o.err_slices;
  end

  // Nothing flagged outside a response
  a_no_err_when_idle: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !rsp_o.valid |-> (rsp_o.err_slices == '0 && !rsp_o.parity_err)
  ) else $error("mem_read_check: error bits set while rsp_o.valid is low");

  // Each response traces back to a read one edge earlier
  a_valid_follows_read: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_o.valid |-> $past(read_i)
  ) else $error("mem_read_check: rsp_o.valid without a read on the previous edge");

endmodule

`default_nettype wire

// ==== verilog/parity_mem_1rw_d1024_w6.sv ====
`timescale 1ns/1ps
`default_nettype none

// Parity array, one even-parity bit per data slice, kept in one macro
module parity_mem_1rw_d1024_w6 (
  input  wire logic                                clk_i,
  input  wire logic                                v_i,
  input  wire logic                                w_i,
  input  wire logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  addr_i,
  input  wire logic [mem_pkg::MEM_DATA_WIDTH-1:0]  data_i,
  input  wire logic [mem_pkg::MEM_NUM_SLICES-1:0]  inject_i, // Flip these parity bits on write
  output logic      [mem_pkg::MEM_NUM_SLICES-1:0]  parity_o
);

  localparam int SPARE_BITS = mem_pkg::MEM_SLICE_WIDTH - mem_pkg::MEM_NUM_SLICES;

  logic [mem_pkg::MEM_NUM_SLICES-1:0]  wr_parity;
  logic [mem_pkg::MEM_SLICE_WIDTH-1:0] wd_byte;
  logic [mem_pkg::MEM_SLICE_WIDTH-1:0] rd_byte;

  // Inject mask lets a test corrupt chosen slices
  assign wr_parity = mem_pkg::slice_parity(data_i) ^ inject_i;

  assign wd_byte = {{SPARE_BITS{1'b0}}, wr_parity}; // Upper two bits stored as zero

  fakeram130_1024x8 parity_ram_inst (
    .clk       (clk_i),
    .ce_in     (v_i),
    .we_in     (w_i),
    .w_mask_in ({mem_pkg::MEM_SLICE_WIDTH{1'b1}}), // Always a full-byte write
    .addr_in   (addr_i),
    .wd_in     (wd_byte),
    .rd_out    (rd_byte)
  );

  assign parity_o = rd_byte[mem_pkg::MEM_NUM_SLICES-1:0];

endmodule

`default_nettype wire

// ==== verilog/hard_mem_1rw_d1024_w46_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

// 46-bit data array built from six byte-wide macros
module hard_mem_1rw_d1024_w46_wrapper (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,      // Only masks the checks below
  input  wire logic                                v_i,
  input  wire logic                                w_i,
  input  wire logic [0:0]                          write_mask_i, // Whole-word write enable
  input  wire logic [mem_pkg::MEM_ADDR_WIDTH-1:0]  addr_i,
  input  wire logic [mem_pkg::MEM_DATA_WIDTH-1:0]  data_i,
  output logic      [mem_pkg::MEM_DATA_WIDTH-1:0]  data_o
);

  localparam int PAD_BITS = mem_pkg::MEM_PAD_WIDTH - mem_pkg::MEM_DATA_WIDTH;

  logic [mem_pkg::MEM_PAD_WIDTH-1:0]   wd_pad;   // Write word, zero-extended to 48
  logic [mem_pkg::MEM_PAD_WIDTH-1:0]   rd_pad;   // All six macro outputs
  logic [mem_pkg::MEM_SLICE_WIDTH-1:0] bit_mask;

  // Top slice only carries 6 real bits
  assign wd_pad = {{PAD_BITS{1'b0}}, data_i};

  // Spare top bits of the last macro are dropped here
  assign data_o = rd_pad[mem_pkg::MEM_DATA_WIDTH-1:0];

  // One mask bit covers every bit of every slice
  assign bit_mask = {mem_pkg::MEM_SLICE_WIDTH{write_mask_i}};

  for (genvar k = 0; k < mem_pkg::MEM_NUM_SLICES; k++) begin : g_slice
    fakeram130_1024x8 ram_inst (
      .clk       (clk_i),
      .ce_in     (v_i),
      .we_in     (w_i),
      .w_mask_in (bit_mask),
      .addr_in   (addr_i),
      .wd_in     (wd_pad[k*mem_pkg::MEM_SLICE_WIDTH +: mem_pkg::MEM_SLICE_WIDTH]),
      .rd_out    (rd_pad[k*mem_pkg::MEM_SLICE_WIDTH +: mem_pkg::MEM_SLICE_WIDTH])
    );
  end

  // An access needs a defined direction and address
  a_access_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> !$isunknown({w_i, addr_i})
  ) else $error("hard_mem wrapper: w_i/addr_i unknown during access");

  // Write data and mask known on writes
  a_write_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (v_i && w_i) |-> !$isunknown({write_mask_i, data_i})
  ) else $error("hard_mem wrapper: write data or mask unknown");

endmodule

`default_nettype wire

// ==== verilog/fakeram130_1024x8.sv ====
`timescale 1ns/1ps
`default_nettype none

// Behavioral stand-in for the 1024x8 single-port macro
module fakeram130_1024x8 (
  input  wire logic                                 clk,
  input  wire logic                                 ce_in,     // Chip enable
  input  wire logic                                 we_in,     // Write when enabled
  input  wire logic [mem_pkg::MEM_SLICE_WIDTH-1:0]  w_mask_in, // Per-bit write enable
  input  wire logic [mem_pkg::MEM_ADDR_WIDTH-1:0]   addr_in,
  input  wire logic [mem_pkg::MEM_SLICE_WIDTH-1:0]  wd_in,
  output logic      [mem_pkg::MEM_SLICE_WIDTH-1:0]  rd_out
);

  logic [mem_pkg::MEM_SLICE_WIDTH-1:0] mem [0:mem_pkg::MEM_DEPTH-1];

  logic do_write;
  logic do_read;

  assign do_write = ce_in & we_in;
  assign do_read  = ce_in & ~we_in;

  // Masked write, untouched bits keep their old value
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int b = 0; b < mem_pkg::MEM_SLICE_WIDTH; b++) begin
        if (w_mask_in[b]) begin
          mem[addr_in][b] <= wd_in[b];
        end
      end
    end
  end

  // Read port holds its last value through writes and idle cycles
  always_ff @(posedge clk) begin
    if (do_read) begin
      rd_out <= mem[addr_in];
    end
  end

  // Enables must be known once the clock is running
  a_enables_known: assert property (
    @(posedge clk) ##1 !$isunknown({ce_in, we_in})
  ) else $error("fakeram130_1024x8: ce_in/we_in unknown");

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  localparam int MEM_ADDR_WIDTH  = 10;
  localparam int MEM_DATA_WIDTH  = 46;
  localparam int MEM_SLICE_WIDTH = 8;
  localparam int MEM_NUM_SLICES  = 6;
  localparam int MEM_DEPTH       = 1 << MEM_ADDR_WIDTH;
  localparam int MEM_PAD_WIDTH   = MEM_NUM_SLICES * MEM_SLICE_WIDTH; // Word padded to whole slices

  typedef struct packed {
    logic                        v;      // Access strobe
    logic                        w;      // High for write
    logic [MEM_ADDR_WIDTH-1:0]   addr;
    logic [MEM_DATA_WIDTH-1:0]   data;
    logic [MEM_NUM_SLICES-1:0]   inject; // Parity bits to flip on write
  } mem_req_t;

  typedef struct packed {
    logic                        valid;
    logic [MEM_DATA_WIDTH-1:0]   data;
    logic                        parity_err;
    logic [MEM_NUM_SLICES-1:0]   err_slices;
  } mem_rsp_t;

  // Even parity of each byte slice, top slice zero-extended
  function automatic logic [MEM_NUM_SLICES-1:0] slice_parity(
    input logic [MEM_DATA_WIDTH-1:0] data
  );
    logic [MEM_PAD_WIDTH-1:0]  padded;
    logic [MEM_NUM_SLICES-1:0] par;
    padded = {{(MEM_PAD_WIDTH - MEM_DATA_WIDTH){1'b0}}, data};
    for (int k = 0; k < MEM_NUM_SLICES; k++) begin
      par[k] = ^padded[k*MEM_SLICE_WIDTH +: MEM_SLICE_WIDTH];
    end
    return par;
  endfunction

endpackage

`default_nettype wire
